// ==== hw/bus_pkg.sv ====
/*
 * Bus address unit package
 * Bus widths, bank numbering, the bank register map
 * and the constants for the low I/O space decode
 */

`default_nettype none

package bus_pkg;

   ////////////////////////////////////////
   // Bus widths
   ////////////////////////////////////////

   // Offset as seen by the processor
   typedef logic [15:0] word_t;
   // Bank extension, becomes address bits 23:16
   typedef logic [7:0]  ext_t;
   // Full physical bus address
   typedef logic [23:0] phys_addr_t;
   // Bank number
   typedef logic [1:0]  bank_sel_t;
   // Register address on the bank write port
   typedef logic [4:0]  raddr_t;

   ////////////////////////////////////////
   // Banks and register map
   ////////////////////////////////////////

   // raddr 00100..00111 map to MB0..MB3
   localparam bank_sel_t BANK_PROGRAM  = 2'd0;
   localparam bank_sel_t BANK_DATA     = 2'd1;
   localparam bank_sel_t BANK_STACK    = 2'd2;
   localparam bank_sel_t BANK_PAGE0    = 2'd3;
   localparam raddr_t    RADDR_MB_BASE = 5'b00100;

   // Memory offsets below this go to MB3 no matter what was asked
   localparam word_t     PAGE0_LIMIT   = 16'h0100;

   ////////////////////////////////////////
   // Low I/O space decode
   ////////////////////////////////////////

   // Offset bits 15:11 must match this for a device enable
   localparam logic [4:0] IO_SYS_SPACE_HI = 5'b00000;
   // Enables for 00xx, 01xx, 02xx, 03xx
   localparam int         IO_DEV_COUNT    = 4;

endpackage

`default_nettype wire

// ==== hw/addr_reg.sv ====
/*
 * Address register, first pipeline stage
 * Holds one accepted offset and its cycle kind.
 * Owns the request handshake and strobes the bank
 * lookup on every accept.
 */

`timescale 1ns/1ns
`default_nettype none

module addr_reg
   import bus_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   // Request channel
   input  logic  req_valid,
   output logic  req_ready,
   input  logic  req_io,
   input  word_t req_offset,
   // Accept strobe to the bank registers
   output logic  take,
   // Stage 1 towards the decoder
   output logic  s1_valid,
   input  logic  s1_ready,
   output logic  s1_io,
   output word_t s1_offset
);

   ////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////

   // Room when empty or when the decoder drains us this cycle
   assign req_ready = !s1_valid || s1_ready;
   // Same condition loads s1_ext in bank_regs
   assign take      = req_valid && req_ready;

   // Valid flag
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
      end else if (req_ready) begin
         // Either refills or empties when drained
         s1_valid <= req_valid;
      end
   end

   // Payload, only touched on an accept
   always_ff @(posedge clk) begin
      if (take) begin
         s1_offset <= req_offset;
         s1_io     <= req_io;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // A stalled request must not change under us
   a_req_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      req_valid && !req_ready |=> $stable(req_offset) && $stable(req_io)
   ) else $error("request payload changed while stalled");

endmodule

`default_nettype wire

// ==== hw/bank_regs.sv ====
/*
 * Memory bank registers
 * MB0 program, MB1 data, MB2 stack, MB3 page 0.
 * Written through a small register port, looked up once
 * per accepted request. Offsets below 0100 always take
 * MB3.
 */

`timescale 1ns/1ns
`default_nettype none

module bank_regs
   import bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   // Register write port, no handshake
   input  logic      bank_wr_en,
   input  raddr_t    bank_wr_raddr,
   input  ext_t      bank_wr_data,
   // Lookup side, in step with addr_reg
   input  logic      take,
   input  bank_sel_t req_bank,
   input  word_t     req_offset,
   output ext_t      s1_ext
);

   ext_t      mb0;
   ext_t      mb1;
   ext_t      mb2;
   ext_t      mb3;
   logic      wr_hit;
   bank_sel_t wr_bank;
   bank_sel_t lookup_bank;
   ext_t      lookup_ext;

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////

   // Only 00100..00111 hit, low two bits pick the register
   assign wr_hit  = bank_wr_en && (bank_wr_raddr[4:2] == RADDR_MB_BASE[4:2]);
   assign wr_bank = bank_wr_raddr[1:0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mb0 <= '0;
         mb1 <= '0;
         mb2 <= '0;
         mb3 <= '0;
      end else if (wr_hit) begin
         case (wr_bank)
            BANK_PROGRAM: mb0 <= bank_wr_data;
            BANK_DATA:    mb1 <= bank_wr_data;
            BANK_STACK:   mb2 <= bank_wr_data;
            BANK_PAGE0:   mb3 <= bank_wr_data;
         endcase
      end
   end

   ////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////

   // Page 0 override
   assign lookup_bank = (req_offset < PAGE0_LIMIT) ? BANK_PAGE0 : req_bank;

   always_comb begin
      case (lookup_bank)
         BANK_PROGRAM: lookup_ext = mb0;
         BANK_DATA:    lookup_ext = mb1;
         BANK_STACK:   lookup_ext = mb2;
         default:      lookup_ext = mb3;
      endcase
   end

   // Registered beside s1_offset
   // A write on the same edge is seen by the next request
   always_ff @(posedge clk) begin
      if (take) begin
         s1_ext <= lookup_ext;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // An X on take would corrupt s1_ext silently
   a_take_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      !$isunknown(take)
   ) else $error("take is unknown");

endmodule

`default_nettype wire

// ==== hw/bus_decoder.sv ====
/*
 * Bus decoder, output stage
 * Builds the 24-bit bus address from stage 1, decodes
 * the four low I/O device enables and holds the bus
 * cycle until the bus takes it.
 */

`timescale 1ns/1ns
`default_nettype none

module bus_decoder
   import bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   // Stage 1 in
   input  logic       s1_valid,
   output logic       s1_ready,
   input  logic       s1_io,
   input  word_t      s1_offset,
   input  ext_t       s1_ext,
   // Bus channel
   output logic       bus_valid,
   input  logic       bus_ready,
   output phys_addr_t bus_ab,
   output logic       bus_io,
   output logic       nsysdev,
   output logic       niodev1xx,
   output logic       niodev2xx,
   output logic       niodev3xx
);

   phys_addr_t              ab_d;
   logic                    io_sys_hit;
   logic [2:0]              dev_sel;
   logic [IO_DEV_COUNT-1:0] nen_d;
   logic [IO_DEV_COUNT-1:0] nen_q;

   ////////////////////////////////////////
   // Address and enable decode
   ////////////////////////////////////////

   // Bank means nothing in I/O space
   assign ab_d = s1_io ? {ext_t'(0), s1_offset} : {s1_ext, s1_offset};

   // Upper offset bits must be clear for the low devices
   assign io_sys_hit = s1_io && (s1_offset[15:11] == IO_SYS_SPACE_HI);
   assign dev_sel    = s1_offset[10:8];

   // Active low, at most one
   always_comb begin
      nen_d = '1;
      for (int i = 0; i < IO_DEV_COUNT; i++) begin
         if (io_sys_hit && (dev_sel == 3'(i))) begin
            nen_d[i] = 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // Stage 2
   ////////////////////////////////////////

   // Load when empty or completing
   assign s1_ready = !bus_valid || bus_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus_valid <= 1'b0;
         nen_q     <= '1;
      end else if (s1_ready) begin
         bus_valid <= s1_valid;
         // Enables drop back high with an empty stage
         nen_q     <= s1_valid ? nen_d : '1;
      end
   end

   always_ff @(posedge clk) begin
      if (s1_valid && s1_ready) begin
         bus_ab <= ab_d;
         bus_io <= s1_io;
      end
   end

   assign nsysdev   = nen_q[0];
   assign niodev1xx = nen_q[1];
   assign niodev2xx = nen_q[2];
   assign niodev3xx = nen_q[3];

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   a_one_enable : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(~nen_q)
   ) else $error("more than one device enable active");

   // No enable outside a valid I/O cycle
   a_enable_io : assert property (
      @(posedge clk) disable iff (!rst_n)
      (nen_q != '1) |-> (bus_valid && bus_io)
   ) else $error("device enable without a valid I/O cycle");

endmodule

`default_nettype wire

// ==== hw/bus_addr_unit.sv ====
/*
 * Bus address unit, top level
 * Address register and bank registers load side by side
 * on each accepted request, the bus decoder merges them
 * into a registered 24-bit bus cycle.
 */

`timescale 1ns/1ns
`default_nettype none

module bus_addr_unit
   import bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   // Request channel
   input  logic       req_valid,
   output logic       req_ready,
   input  logic       req_io,
   input  bank_sel_t  req_bank,
   input  word_t      req_offset,
   // Bank register write port
   input  logic       bank_wr_en,
   input  raddr_t     bank_wr_raddr,
   input  ext_t       bank_wr_data,
   // Bus channel
   output logic       bus_valid,
   input  logic       bus_ready,
   output phys_addr_t bus_ab,
   output logic       bus_io,
   output logic       nsysdev,
   output logic       niodev1xx,
   output logic       niodev2xx,
   output logic       niodev3xx
);

   logic  take;
   logic  s1_valid;
   logic  s1_ready;
   logic  s1_io;
   word_t s1_offset;
   ext_t  s1_ext;

   ////////////////////////////////////////
   // Stage 1, offset and bank side by side
   ////////////////////////////////////////

   addr_reg u_addr_reg (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_io     (req_io),
      .req_offset (req_offset),
      .take       (take),
      .s1_valid   (s1_valid),
      .s1_ready   (s1_ready),
      .s1_io      (s1_io),
      .s1_offset  (s1_offset)
   );

   // Lookup loads on the same take strobe
   bank_regs u_bank_regs (
      .clk           (clk),
      .rst_n         (rst_n),
      .bank_wr_en    (bank_wr_en),
      .bank_wr_raddr (bank_wr_raddr),
      .bank_wr_data  (bank_wr_data),
      .take          (take),
      .req_bank      (req_bank),
      .req_offset    (req_offset),
      .s1_ext        (s1_ext)
   );

   ////////////////////////////////////////
   // Stage 2, bus cycle
   ////////////////////////////////////////

   bus_decoder u_bus_decoder (
      .clk       (clk),
      .rst_n     (rst_n),
      .s1_valid  (s1_valid),
      .s1_ready  (s1_ready),
      .s1_io     (s1_io),
      .s1_offset (s1_offset),
      .s1_ext    (s1_ext),
      .bus_valid (bus_valid),
      .bus_ready (bus_ready),
      .bus_ab    (bus_ab),
      .bus_io    (bus_io),
      .nsysdev   (nsysdev),
      .niodev1xx (niodev1xx),
      .niodev2xx (niodev2xx),
      .niodev3xx (niodev3xx)
   );

endmodule

`default_nettype wire

// ==== tests/tb_checks.svh ====
/*
 * Testbench compare tasks
 * One task per kind of result, typed to the bus types.
 * A mismatch prints a FAIL line and stops the run.
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Full 24-bit bus address
task automatic check_addr(input string name, input phys_addr_t got, input phys_addr_t exp);
   if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
   end
endtask

// Single control or enable bit
task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
   end
endtask

// Bank extension byte
task automatic check_ext(input string name, input ext_t got, input ext_t exp);
   if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
   end
endtask

`endif

// ==== tests/tb_bus_addr_unit.sv ====
/*
 * Bus address unit testbench
 * Directed tests for bank lookup, page 0 override, I/O decode,
 * latency and a random back-pressure stream. A reference model
 * predicts every bus cycle from the bank contents.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_bus_addr_unit
   import bus_pkg::*;
;

   localparam int CLK_PERIOD   = 100;
   // Directed requests plus the random stream
   localparam int NUM_REQUESTS = 68;
   localparam int TIMEOUT_NS   = (NUM_REQUESTS + 50) * 10 * CLK_PERIOD;

   logic       clk;
   logic       rst_n;
   logic       req_valid;
   logic       req_ready;
   logic       req_io;
   bank_sel_t  req_bank;
   word_t      req_offset;
   logic       bank_wr_en;
   raddr_t     bank_wr_raddr;
   ext_t       bank_wr_data;
   logic       bus_valid;
   logic       bus_ready;
   phys_addr_t bus_ab;
   logic       bus_io;
   logic       nsysdev;
   logic       niodev1xx;
   logic       niodev2xx;
   logic       niodev3xx;

   int         err_count = 0;
   integer     seed = 26693;

   // Reference model state
   ext_t       model_mb [4];
   phys_addr_t exp_ab_q [$];
   logic       exp_io_q [$];
   logic [3:0] exp_nen_q [$];

   `include "tb_checks.svh"

   bus_addr_unit u_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .req_valid     (req_valid),
      .req_ready     (req_ready),
      .req_io        (req_io),
      .req_bank      (req_bank),
      .req_offset    (req_offset),
      .bank_wr_en    (bank_wr_en),
      .bank_wr_raddr (bank_wr_raddr),
      .bank_wr_data  (bank_wr_data),
      .bus_valid     (bus_valid),
      .bus_ready     (bus_ready),
      .bus_ab        (bus_ab),
      .bus_io        (bus_io),
      .nsysdev       (nsysdev),
      .niodev1xx     (niodev1xx),
      .niodev2xx     (niodev2xx),
      .niodev3xx     (niodev3xx)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("ERROR watchdog timeout, the bus pipeline stopped making progress");
      $display("tests failed");
      $fatal(1);
   end

   task automatic report_failure(input string what);
      err_count++;
      $display("ERROR t=%0t %s", $time, what);
      $display("tests failed");
      $fatal(1);
   endtask

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // I/O has no bank, low memory offsets go to MB3
   function automatic phys_addr_t predict_ab(input logic io, input bank_sel_t bank,
                                             input word_t offset);
      bank_sel_t eff;
      if (io) begin
         return {8'h00, offset};
      end
      eff = (offset < PAGE0_LIMIT) ? BANK_PAGE0 : bank;
      return {model_mb[eff], offset};
   endfunction

   // Offsets 0000..03FF pick one of four devices by bits 9:8
   function automatic logic [3:0] predict_nen(input logic io, input word_t offset);
      logic [3:0] n;
      n = 4'hF;
      if (io && offset < 16'h0400) begin
         n[offset[9:8]] = 1'b0;
      end
      return n;
   endfunction

   // Pre-edge values, so order against DUT flops does not matter
   always @(posedge clk) begin
      if (rst_n) begin
         // Stall only with both stages full and the bus stalled
         check_flag("req_ready", req_ready, !(exp_ab_q.size() == 2 && !bus_ready));
         if (!bus_valid) begin
            check_flag("nsysdev", nsysdev, 1'b1);
            check_flag("niodev1xx", niodev1xx, 1'b1);
            check_flag("niodev2xx", niodev2xx, 1'b1);
            check_flag("niodev3xx", niodev3xx, 1'b1);
         end
         if (bus_valid && bus_ready) begin
            if (exp_ab_q.size() == 0) begin
               report_failure("bus cycle completed with no request outstanding");
            end
            // Bank extension first, then the whole address
            check_ext("bus_ab[23:16]", bus_ab[23:16], exp_ab_q[0][23:16]);
            check_addr("bus_ab", bus_ab, exp_ab_q[0]);
            check_flag("bus_io", bus_io, exp_io_q[0]);
            check_flag("nsysdev", nsysdev, exp_nen_q[0][0]);
            check_flag("niodev1xx", niodev1xx, exp_nen_q[0][1]);
            check_flag("niodev2xx", niodev2xx, exp_nen_q[0][2]);
            check_flag("niodev3xx", niodev3xx, exp_nen_q[0][3]);
            void'(exp_ab_q.pop_front());
            void'(exp_io_q.pop_front());
            void'(exp_nen_q.pop_front());
         end
         // Request on this edge still sees the old bank value
         if (req_valid && req_ready) begin
            exp_ab_q.push_back(predict_ab(req_io, req_bank, req_offset));
            exp_io_q.push_back(req_io);
            exp_nen_q.push_back(predict_nen(req_io, req_offset));
         end
         if (bank_wr_en && bank_wr_raddr >= 5'd4 && bank_wr_raddr <= 5'd7) begin
            model_mb[bank_wr_raddr[1:0]] = bank_wr_data;
         end
      end
   end

   ////////////////////////////////////////
   // Drivers
   ////////////////////////////////////////

   task automatic write_bank(input raddr_t raddr, input ext_t data);
      @(negedge clk);
      bank_wr_en    = 1'b1;
      bank_wr_raddr = raddr;
      bank_wr_data  = data;
      @(negedge clk);
      bank_wr_en    = 1'b0;
   endtask

   // Returns right after the accepting edge
   task automatic send_req(input logic io, input bank_sel_t bank, input word_t offset);
      @(negedge clk);
      req_valid  = 1'b1;
      req_io     = io;
      req_bank   = bank;
      req_offset = offset;
      @(posedge clk);
      while (!req_ready) @(posedge clk);
   endtask

   task automatic drain();
      @(negedge clk);
      req_valid = 1'b0;
      while (exp_ab_q.size() != 0) @(negedge clk);
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   task automatic test_reset_state();
      check_flag("req_ready", req_ready, 1'b1);
      check_flag("bus_valid", bus_valid, 1'b0);
      check_flag("nsysdev", nsysdev, 1'b1);
      check_flag("niodev1xx", niodev1xx, 1'b1);
      check_flag("niodev2xx", niodev2xx, 1'b1);
      check_flag("niodev3xx", niodev3xx, 1'b1);
   endtask

   task automatic test_bank_lookup();
      int b;
      write_bank(5'b00100, 8'h11);
      write_bank(5'b00101, 8'h22);
      write_bank(5'b00110, 8'h33);
      write_bank(5'b00111, 8'h44);
      for (b = 0; b < 4; b++) send_req(1'b0, b[1:0], {b[1:0], 14'h0321});
      drain();
      // Outside the register window, must leave MB0..MB3 alone
      write_bank(5'b01000, 8'hEE);
      write_bank(5'b00011, 8'hEE);
      write_bank(5'b11111, 8'hEE);
      for (b = 0; b < 4; b++) send_req(1'b0, b[1:0], {b[1:0], 14'h0321});
      drain();
   endtask

   task automatic test_page0();
      int b;
      for (b = 0; b < 4; b++) begin
         send_req(1'b0, b[1:0], 16'h0000);
         send_req(1'b0, b[1:0], 16'h0042);
         send_req(1'b0, b[1:0], 16'h00FF);
      end
      drain();
   endtask

   task automatic test_io_decode();
      int k;
      for (k = 0; k < 4; k++) send_req(1'b1, BANK_STACK, {6'd0, k[1:0], 8'h00});
      // Upper I/O space, no enable
      send_req(1'b1, BANK_STACK, 16'h0400);
      send_req(1'b1, BANK_STACK, 16'h0800);
      // Memory cycle in the same range keeps all enables high
      send_req(1'b0, BANK_DATA, 16'h0200);
      drain();
   endtask

   // Valid in the second cycle counted from the accept cycle
   task automatic test_latency();
      @(negedge clk);
      req_valid  = 1'b1;
      req_io     = 1'b0;
      req_bank   = BANK_DATA;
      req_offset = 16'h8000;
      @(posedge clk);
      if (!req_ready) begin
         report_failure("request not accepted on an idle pipeline");
      end
      @(negedge clk);
      req_valid = 1'b0;
      check_flag("bus_valid", bus_valid, 1'b0);
      @(negedge clk);
      check_flag("bus_valid", bus_valid, 1'b1);
      drain();
   endtask

   // Random bus stalls, gaps and bank writes in one process
   task automatic test_stream(input int count);
      int   sent;
      int   r;
      logic accepted;
      sent     = 0;
      accepted = 1'b1;
      while (sent < count || !accepted) begin
         @(negedge clk);
         r             = $random(seed);
         bus_ready     = r[0];
         r             = $random(seed);
         bank_wr_en    = (r[2:0] == 3'd0);
         bank_wr_raddr = r[7:3];
         bank_wr_data  = r[15:8];
         if (accepted) begin
            r = $random(seed);
            if (sent < count && r[1:0] != 2'd0) begin
               req_valid  = 1'b1;
               req_io     = (r[3:2] == 2'd0);
               req_bank   = r[5:4];
               // Half the offsets land in page 0 or the low devices
               req_offset = r[6] ? {6'd0, r[25:16]} : r[31:16];
               sent++;
            end else begin
               req_valid = 1'b0;
            end
         end
         @(posedge clk);
         accepted = !req_valid || req_ready;
      end
      @(negedge clk);
      req_valid  = 1'b0;
      bank_wr_en = 1'b0;
      bus_ready  = 1'b1;
      drain();
   endtask

   initial begin
      rst_n         = 1'b0;
      req_valid     = 1'b0;
      req_io        = 1'b0;
      req_bank      = '0;
      req_offset    = '0;
      bank_wr_en    = 1'b0;
      bank_wr_raddr = '0;
      bank_wr_data  = '0;
      bus_ready     = 1'b1;
      for (int i = 0; i < 4; i++) model_mb[i] = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      test_reset_state();
      test_bank_lookup();
      test_page0();
      test_io_decode();
      test_latency();
      test_stream(40);
      if (err_count == 0 && exp_ab_q.size() == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("tests failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tests
hw/bus_pkg.sv
hw/addr_reg.sv
hw/bank_regs.sv
hw/bus_decoder.sv
hw/bus_addr_unit.sv
tests/tb_bus_addr_unit.sv

// ==== Makefile ====
# Verilator flow for the bus address unit
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_bus_addr_unit
DUT_TOP   ?= bus_addr_unit
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_FLAGS ?= --binary --timing --assert -j 0
RTL_FILES ?= hw/bus_pkg.sv hw/addr_reg.sv hw/bank_regs.sv hw/bus_decoder.sv \
             hw/bus_addr_unit.sv
FAIL_TEXT ?= tests failed
PASS_TEXT ?= all tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_FILES) --top-module $(DUT_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# The log decides the result, the simulator exit code is not trusted
sim: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "SIMULATION FAILED"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "SIMULATION DID NOT COMPLETE"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
